//--- design/soc_bus_pkg.sv
// Bus widths, memory map pages, memory depths, register offsets and the fetch NOP word.
package soc_bus_pkg;

	localparam int ADDR_W = 30;
	localparam int DATA_W = 32;
	localparam int BSEL_W = DATA_W / 8;

	// a word address splits into a page number and a word offset.
	localparam int PAGE_W = 20;
	localparam int OFS_W = 10;

	localparam logic [PAGE_W-1:0] RAM_PAGE = 20'h00000;
	localparam logic [PAGE_W-1:0] ROM_PAGE = 20'h10000;
	localparam logic [PAGE_W-1:0] IRQ_PAGE = 20'h80002;
	localparam logic [PAGE_W-1:0] TIMER_PAGE = 20'h80003;

	localparam int RAM_WORDS = 256;
	localparam int RAM_AW = $clog2(RAM_WORDS);
	localparam int ROM_WORDS = 16;
	localparam int ROM_AW = $clog2(ROM_WORDS);
	localparam ROM_FILE = "design/boot_rom.hex";

	// irq inputs 0 and 1 come from the timers, the rest are external.
	localparam int NR_TIMERS = 2;
	localparam int NR_IRQS = 4;
	localparam int TMR_IDX_W = $clog2(NR_TIMERS);

	localparam logic [OFS_W-1:0] IRQ_STATUS_OFS = 10'd0;
	localparam logic [OFS_W-1:0] IRQ_ENABLE_OFS = 10'd1;

	localparam int TMR_STRIDE = 4;
	localparam int TMR_REG_W = $clog2(TMR_STRIDE);
	localparam logic [TMR_REG_W-1:0] TMR_COUNT_OFS = 2'd0;
	localparam logic [TMR_REG_W-1:0] TMR_RELOAD_OFS = 2'd1;
	localparam logic [TMR_REG_W-1:0] TMR_CTRL_OFS = 2'd2;

	localparam logic [DATA_W-1:0] INSTR_NOP = 32'h0000_0000;

endpackage

//--- design/bus_if.sv
// Data-slave bus interface and fetch-slave interface, each with req, slv and rsp modports.
`timescale 1ns/1ps

interface bus_if;
	import soc_bus_pkg::*;

	logic access;
	logic [OFS_W-1:0] addr;
	logic [DATA_W-1:0] wr_val;
	logic wr_en;
	logic [BSEL_W-1:0] bytesel;
	logic [DATA_W-1:0] rd_data;
	logic ack;
	logic error;

	modport req (output access, addr, wr_val, wr_en, bytesel);
	modport slv (input access, addr, wr_val, wr_en, bytesel, output rd_data, ack, error);
	modport rsp (input rd_data, ack, error);
endinterface

interface fetch_if;
	import soc_bus_pkg::*;

	logic access;
	logic [OFS_W-1:0] addr;
	logic [DATA_W-1:0] rd_data;
	logic ack;

	modport req (output access, addr);
	modport slv (input access, addr, output rd_data, ack);
	modport rsp (input rd_data, ack);
endinterface

//--- design/bus_addr_decode.sv
// Page decoder for data and fetch addresses with registered miss pulses.
`timescale 1ns/1ps

module bus_addr_decode (
	input logic clk,
	input logic i_arst_n,
	input logic i_d_access,
	input logic [soc_bus_pkg::ADDR_W-1:0] i_d_addr,
	input logic [soc_bus_pkg::DATA_W-1:0] i_d_wr_val,
	input logic i_d_wr_en,
	input logic [soc_bus_pkg::BSEL_W-1:0] i_d_bytesel,
	input logic i_i_access,
	input logic [soc_bus_pkg::ADDR_W-1:0] i_i_addr,
	bus_if.req d_ram,
	bus_if.req d_rom,
	bus_if.req d_irq,
	bus_if.req d_tmr,
	fetch_if.req f_ram,
	fetch_if.req f_rom,
	output logic o_d_miss,
	output logic o_i_miss
);
	import soc_bus_pkg::*;

	logic [PAGE_W-1:0] d_page;
	logic [PAGE_W-1:0] i_page;
	logic [OFS_W-1:0] d_ofs;
	logic [OFS_W-1:0] i_ofs;
	logic d_ram_hit;
	logic d_rom_hit;
	logic d_irq_hit;
	logic d_tmr_hit;
	logic i_ram_hit;
	logic i_rom_hit;

	assign d_page = i_d_addr[ADDR_W-1 -: PAGE_W];
	assign d_ofs = i_d_addr[OFS_W-1:0];
	assign i_page = i_i_addr[ADDR_W-1 -: PAGE_W];
	assign i_ofs = i_i_addr[OFS_W-1:0];

	// the memories are smaller than a page, so the offset is range checked too.
	assign d_ram_hit = (d_page == RAM_PAGE) && (d_ofs < OFS_W'(RAM_WORDS));
	assign d_rom_hit = (d_page == ROM_PAGE) && (d_ofs < OFS_W'(ROM_WORDS));
	assign d_irq_hit = (d_page == IRQ_PAGE);
	assign d_tmr_hit = (d_page == TIMER_PAGE);
	assign i_ram_hit = (i_page == RAM_PAGE) && (i_ofs < OFS_W'(RAM_WORDS));
	assign i_rom_hit = (i_page == ROM_PAGE) && (i_ofs < OFS_W'(ROM_WORDS));

	assign d_ram.access = i_d_access && d_ram_hit;
	assign d_ram.addr = d_ofs;
	assign d_ram.wr_val = i_d_wr_val;
	assign d_ram.wr_en = i_d_wr_en;
	assign d_ram.bytesel = i_d_bytesel;

	assign d_rom.access = i_d_access && d_rom_hit;
	assign d_rom.addr = d_ofs;
	assign d_rom.wr_val = i_d_wr_val;
	assign d_rom.wr_en = i_d_wr_en;
	assign d_rom.bytesel = i_d_bytesel;

	assign d_irq.access = i_d_access && d_irq_hit;
	assign d_irq.addr = d_ofs;
	assign d_irq.wr_val = i_d_wr_val;
	assign d_irq.wr_en = i_d_wr_en;
	assign d_irq.bytesel = i_d_bytesel;

	assign d_tmr.access = i_d_access && d_tmr_hit;
	assign d_tmr.addr = d_ofs;
	assign d_tmr.wr_val = i_d_wr_val;
	assign d_tmr.wr_en = i_d_wr_en;
	assign d_tmr.bytesel = i_d_bytesel;

	assign f_ram.access = i_i_access && i_ram_hit;
	assign f_ram.addr = i_ofs;
	assign f_rom.access = i_i_access && i_rom_hit;
	assign f_rom.addr = i_ofs;

	// misses are answered here with the same one cycle latency as a slave.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_d_miss <= 1'b0;
			o_i_miss <= 1'b0;
		end else begin
			o_d_miss <= i_d_access && !(d_ram_hit || d_rom_hit || d_irq_hit || d_tmr_hit);
			o_i_miss <= i_i_access && !(i_ram_hit || i_rom_hit);
		end
	end

	a_one_data_sel: assert property (@(posedge clk) disable iff (!i_arst_n)
		$onehot0({d_ram.access, d_rom.access, d_irq.access, d_tmr.access}));

endmodule

//--- design/onchip_ram.sv
// Dual-port on-chip word RAM with byte-masked data writes and a fetch read port.
`timescale 1ns/1ps

module onchip_ram (
	input logic clk,
	bus_if.slv d_bus,
	fetch_if.slv f_bus
);
	import soc_bus_pkg::*;

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0] d_idx;
	logic [RAM_AW-1:0] f_idx;

	// the decoder has already range checked the offset.
	assign d_idx = d_bus.addr[RAM_AW-1:0];
	assign f_idx = f_bus.addr[RAM_AW-1:0];

	always_ff @(posedge clk) begin
		if (d_bus.access && d_bus.wr_en) begin
			for (int b = 0; b < BSEL_W; b++) begin
				if (d_bus.bytesel[b])
					mem[d_idx][8*b +: 8] <= d_bus.wr_val[8*b +: 8];
			end
		end
	end

	// read data is only looked at in the ack cycle, so it is sampled every clock.
	always_ff @(posedge clk) begin
		d_bus.rd_data <= mem[d_idx];
		f_bus.rd_data <= mem[f_idx];
	end

	always_ff @(posedge clk) begin
		d_bus.ack <= d_bus.access;
		f_bus.ack <= f_bus.access;
	end

	assign d_bus.error = 1'b0;

endmodule

//--- design/boot_rom.sv
// Boot ROM loaded from a hex image, with a data read port and a fetch port.
`timescale 1ns/1ps

module boot_rom (
	input logic clk,
	input logic i_arst_n,
	bus_if.slv d_bus,
	fetch_if.slv f_bus
);
	import soc_bus_pkg::*;

	logic [DATA_W-1:0] mem [ROM_WORDS];

	initial $readmemh(ROM_FILE, mem);

	always_ff @(posedge clk) begin
		d_bus.rd_data <= mem[d_bus.addr[ROM_AW-1:0]];
		f_bus.rd_data <= mem[f_bus.addr[ROM_AW-1:0]];
	end

	// writes get a normal ack but never touch the array.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			d_bus.ack <= 1'b0;
			f_bus.ack <= 1'b0;
		end else begin
			d_bus.ack <= d_bus.access;
			f_bus.ack <= f_bus.access;
		end
	end

	assign d_bus.error = 1'b0;

endmodule

//--- design/irq_ctrl.sv
// Interrupt controller with edge-latched pending bits, enable mask and write-one-to-clear.
`timescale 1ns/1ps

module irq_ctrl (
	input logic clk,
	input logic i_arst_n,
	bus_if.slv d_bus,
	input logic [soc_bus_pkg::NR_IRQS-1:0] i_irqs,
	output logic o_irq_req
);
	import soc_bus_pkg::*;

	logic [NR_IRQS-1:0] pending;
	logic [NR_IRQS-1:0] enable;
	logic [NR_IRQS-1:0] irqs_q;
	logic [NR_IRQS-1:0] rise;
	logic [NR_IRQS-1:0] clr;
	logic wr;
	logic reg_ok;

	assign wr = d_bus.access && d_bus.wr_en;
	assign reg_ok = (d_bus.addr == IRQ_STATUS_OFS) || (d_bus.addr == IRQ_ENABLE_OFS);
	assign rise = i_irqs & ~irqs_q;
	assign clr = (wr && d_bus.addr == IRQ_STATUS_OFS) ? d_bus.wr_val[NR_IRQS-1:0] : '0;

	// a new edge wins over a clear in the same cycle.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			irqs_q <= '0;
			pending <= '0;
			enable <= '0;
			d_bus.ack <= 1'b0;
			d_bus.error <= 1'b0;
		end else begin
			irqs_q <= i_irqs;
			pending <= (pending & ~clr) | rise;
			if (wr && d_bus.addr == IRQ_ENABLE_OFS)
				enable <= d_bus.wr_val[NR_IRQS-1:0];
			d_bus.ack <= d_bus.access;
			d_bus.error <= d_bus.access && !reg_ok;
		end
	end

	always_ff @(posedge clk) begin
		case (d_bus.addr)
			IRQ_STATUS_OFS: d_bus.rd_data <= DATA_W'(pending);
			IRQ_ENABLE_OFS: d_bus.rd_data <= DATA_W'(enable);
			default: d_bus.rd_data <= '0;
		endcase
	end

	assign o_irq_req = |(pending & enable);

	// writing a zero mask silences the request from the next cycle on.
	a_masked_quiet: assert property (@(posedge clk) disable iff (!i_arst_n)
		(wr && d_bus.addr == IRQ_ENABLE_OFS && d_bus.wr_val[NR_IRQS-1:0] == '0)
		|=> !o_irq_req);

endmodule

//--- design/timer_block.sv
// Two reload down-counters with count, reload and control registers and irq pulses.
`timescale 1ns/1ps

module timer_block (
	input logic clk,
	input logic i_arst_n,
	bus_if.slv d_bus,
	output logic [soc_bus_pkg::NR_TIMERS-1:0] o_irqs
);
	import soc_bus_pkg::*;

	logic [DATA_W-1:0] count [NR_TIMERS];
	logic [DATA_W-1:0] reload [NR_TIMERS];
	logic [NR_TIMERS-1:0] enable;
	logic [OFS_W-TMR_REG_W-1:0] sel;
	logic [TMR_IDX_W-1:0] idx;
	logic [TMR_REG_W-1:0] reg_ofs;
	logic sel_ok;
	logic reg_ok;
	logic wr_ok;

	// each timer owns TMR_STRIDE words of the page.
	assign sel = d_bus.addr[OFS_W-1:TMR_REG_W];
	assign idx = sel[TMR_IDX_W-1:0];
	assign reg_ofs = d_bus.addr[TMR_REG_W-1:0];
	assign sel_ok = sel < (OFS_W-TMR_REG_W)'(NR_TIMERS);

	// count is read-only.
	assign reg_ok = (reg_ofs == TMR_RELOAD_OFS) || (reg_ofs == TMR_CTRL_OFS) ||
		(reg_ofs == TMR_COUNT_OFS && !d_bus.wr_en);
	assign wr_ok = d_bus.access && d_bus.wr_en && sel_ok && reg_ok;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int t = 0; t < NR_TIMERS; t++) begin
				count[t] <= '0;
				reload[t] <= '0;
			end
			enable <= '0;
			o_irqs <= '0;
			d_bus.ack <= 1'b0;
			d_bus.error <= 1'b0;
		end else begin
			for (int t = 0; t < NR_TIMERS; t++) begin
				o_irqs[t] <= 1'b0;
				if (wr_ok && int'(idx) == t && reg_ofs == TMR_RELOAD_OFS) begin
					reload[t] <= d_bus.wr_val;
					count[t] <= d_bus.wr_val;
				end else if (enable[t]) begin
					if (count[t] == '0) begin
						count[t] <= reload[t];
						o_irqs[t] <= 1'b1;
					end else begin
						count[t] <= count[t] - 1'b1;
					end
				end
				if (wr_ok && int'(idx) == t && reg_ofs == TMR_CTRL_OFS)
					enable[t] <= d_bus.wr_val[0];
			end
			d_bus.ack <= d_bus.access;
			d_bus.error <= d_bus.access && !(sel_ok && reg_ok);
		end
	end

	always_ff @(posedge clk) begin
		if (!sel_ok) begin
			d_bus.rd_data <= '0;
		end else begin
			case (reg_ofs)
				TMR_COUNT_OFS: d_bus.rd_data <= count[idx];
				TMR_RELOAD_OFS: d_bus.rd_data <= reload[idx];
				TMR_CTRL_OFS: d_bus.rd_data <= DATA_W'(enable[idx]);
				default: d_bus.rd_data <= '0;
			endcase
		end
	end

endmodule

//--- design/bus_response_mux.sv
// Response mux merging slave acks, errors and read data with the miss responses.
`timescale 1ns/1ps

module bus_response_mux (
	input logic clk,
	input logic i_arst_n,
	bus_if.rsp d_ram,
	bus_if.rsp d_rom,
	bus_if.rsp d_irq,
	bus_if.rsp d_tmr,
	fetch_if.rsp f_ram,
	fetch_if.rsp f_rom,
	input logic i_d_miss,
	input logic i_i_miss,
	output logic [soc_bus_pkg::DATA_W-1:0] o_d_data,
	output logic o_d_ack,
	output logic o_d_error,
	output logic [soc_bus_pkg::DATA_W-1:0] o_i_data,
	output logic o_i_ack,
	output logic o_i_error
);
	import soc_bus_pkg::*;

	assign o_d_ack = d_ram.ack | d_rom.ack | d_irq.ack | d_tmr.ack | i_d_miss;
	assign o_d_error = d_ram.error | d_rom.error | d_irq.error | d_tmr.error | i_d_miss;

	// a miss has no slave ack, so it falls through to zero.
	always_comb begin
		if (d_ram.ack)
			o_d_data = d_ram.rd_data;
		else if (d_rom.ack)
			o_d_data = d_rom.rd_data;
		else if (d_irq.ack)
			o_d_data = d_irq.rd_data;
		else if (d_tmr.ack)
			o_d_data = d_tmr.rd_data;
		else
			o_d_data = '0;
	end

	assign o_i_ack = f_ram.ack | f_rom.ack | i_i_miss;
	assign o_i_error = i_i_miss;

	always_comb begin
		if (f_ram.ack)
			o_i_data = f_ram.rd_data;
		else if (f_rom.ack)
			o_i_data = f_rom.rd_data;
		else
			o_i_data = INSTR_NOP;
	end

	a_one_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
		$onehot0({d_ram.ack, d_rom.ack, d_irq.ack, d_tmr.ack, i_d_miss}) &&
		$onehot0({f_ram.ack, f_rom.ack, i_i_miss}));

	a_err_with_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
		(({d_ram.error, d_rom.error, d_irq.error, d_tmr.error} &
		~{d_ram.ack, d_rom.ack, d_irq.ack, d_tmr.ack}) == 4'b0000));

endmodule

//--- design/soc_fabric_top.sv
// Bus fabric top level wiring the address decoder, the four slaves and the response mux.
`timescale 1ns/1ps

module soc_fabric_top (
	input logic clk,
	input logic i_arst_n,
	input logic i_d_access,
	input logic [soc_bus_pkg::ADDR_W-1:0] i_d_addr,
	input logic [soc_bus_pkg::DATA_W-1:0] i_d_wr_val,
	input logic i_d_wr_en,
	input logic [soc_bus_pkg::BSEL_W-1:0] i_d_bytesel,
	output logic [soc_bus_pkg::DATA_W-1:0] o_d_data,
	output logic o_d_ack,
	output logic o_d_error,
	input logic i_i_access,
	input logic [soc_bus_pkg::ADDR_W-1:0] i_i_addr,
	output logic [soc_bus_pkg::DATA_W-1:0] o_i_data,
	output logic o_i_ack,
	output logic o_i_error,
	input logic [soc_bus_pkg::NR_IRQS-soc_bus_pkg::NR_TIMERS-1:0] i_ext_irqs,
	output logic o_irq_req
);
	import soc_bus_pkg::*;

	logic d_miss;
	logic i_miss;
	logic [NR_TIMERS-1:0] tmr_irqs;
	logic [NR_IRQS-1:0] irqs;

	bus_if d_ram ();
	bus_if d_rom ();
	bus_if d_irq ();
	bus_if d_tmr ();
	fetch_if f_ram ();
	fetch_if f_rom ();

	// timer interrupts take the low inputs.
	assign irqs = {i_ext_irqs, tmr_irqs};

	bus_addr_decode u_decode (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_d_access(i_d_access),
		.i_d_addr(i_d_addr),
		.i_d_wr_val(i_d_wr_val),
		.i_d_wr_en(i_d_wr_en),
		.i_d_bytesel(i_d_bytesel),
		.i_i_access(i_i_access),
		.i_i_addr(i_i_addr),
		.d_ram(d_ram),
		.d_rom(d_rom),
		.d_irq(d_irq),
		.d_tmr(d_tmr),
		.f_ram(f_ram),
		.f_rom(f_rom),
		.o_d_miss(d_miss),
		.o_i_miss(i_miss)
	);

	onchip_ram u_ram (
		.clk(clk),
		.d_bus(d_ram),
		.f_bus(f_ram)
	);

	boot_rom u_rom (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.d_bus(d_rom),
		.f_bus(f_rom)
	);

	irq_ctrl u_irq (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.d_bus(d_irq),
		.i_irqs(irqs),
		.o_irq_req(o_irq_req)
	);

	timer_block u_timers (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.d_bus(d_tmr),
		.o_irqs(tmr_irqs)
	);

	bus_response_mux u_mux (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.d_ram(d_ram),
		.d_rom(d_rom),
		.d_irq(d_irq),
		.d_tmr(d_tmr),
		.f_ram(f_ram),
		.f_rom(f_rom),
		.i_d_miss(d_miss),
		.i_i_miss(i_miss),
		.o_d_data(o_d_data),
		.o_d_ack(o_d_ack),
		.o_d_error(o_d_error),
		.o_i_data(o_i_data),
		.o_i_ack(o_i_ack),
		.o_i_error(o_i_error)
	);

endmodule

//--- tests/tb_soc_fabric.sv
// Directed testbench for the bus fabric with clock, reset, compare task, tests and final report.
`timescale 1ns/1ps

module tb_soc_fabric;

	localparam logic [19:0] RAM_PG = 20'h00000;
	localparam logic [19:0] ROM_PG = 20'h10000;
	localparam logic [19:0] IRQ_PG = 20'h80002;
	localparam logic [19:0] TMR_PG = 20'h80003;
	localparam logic [19:0] HOLE_PG = 20'h40000;
	localparam logic [31:0] NOP_WORD = 32'h0000_0000;
	localparam int ACK_TIMEOUT = 16;
	localparam int IRQ_TIMEOUT = 200;

	logic clk;
	logic arst_n;
	logic d_access;
	logic [29:0] d_addr;
	logic [31:0] d_wr_val;
	logic d_wr_en;
	logic [3:0] d_bytesel;
	logic [31:0] d_data;
	logic d_ack;
	logic d_error;
	logic f_access;
	logic [29:0] f_addr;
	logic [31:0] f_data;
	logic f_ack;
	logic f_error;
	logic [1:0] ext_irqs;
	logic irq_req;

	logic [31:0] ram_model [256];
	logic [31:0] rom_image [16];
	integer seed;
	int errors;

	soc_fabric_top dut (
		.clk(clk),
		.i_arst_n(arst_n),
		.i_d_access(d_access),
		.i_d_addr(d_addr),
		.i_d_wr_val(d_wr_val),
		.i_d_wr_en(d_wr_en),
		.i_d_bytesel(d_bytesel),
		.o_d_data(d_data),
		.o_d_ack(d_ack),
		.o_d_error(d_error),
		.i_i_access(f_access),
		.i_i_addr(f_addr),
		.o_i_data(f_data),
		.o_i_ack(f_ack),
		.o_i_error(f_error),
		.i_ext_irqs(ext_irqs),
		.o_irq_req(irq_req)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			abort_run($sformatf("Mismatch at time %0t: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	// a write only changes the bytes whose select bit is set.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] val,
			input logic [3:0] bsel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (bsel[b])
				res[8*b +: 8] = val[8*b +: 8];
		end
		return res;
	endfunction

	task automatic issue_access(input logic [29:0] addr, input logic wr, input logic [31:0] val,
			input logic [3:0] bsel, output logic [31:0] rdata, output logic err);
		int waited;
		logic got_ack;
		@(negedge clk);
		d_access = 1'b1;
		d_addr = addr;
		d_wr_en = wr;
		d_wr_val = val;
		d_bytesel = bsel;
		waited = 0;
		got_ack = 1'b0;
		while (!got_ack) begin
			@(negedge clk);
			waited++;
			got_ack = d_ack;
			rdata = d_data;
			err = d_error;
			d_access = 1'b0;
			if (!got_ack && waited >= ACK_TIMEOUT)
				abort_run("timeout, no data ack arrived");
		end
		check(32'(waited), 32'd1, "data ack latency");
	endtask

	task automatic write_word(input logic [29:0] addr, input logic [31:0] val,
			input logic [3:0] bsel, input logic exp_err, input string what);
		logic [31:0] rdata;
		logic err;
		issue_access(addr, 1'b1, val, bsel, rdata, err);
		check(32'(err), 32'(exp_err), $sformatf("%s error flag", what));
	endtask

	// a write to an unmapped address comes back with error and zero data.
	task automatic missed_write(input logic [29:0] addr, input logic [31:0] val,
			input string what);
		logic [31:0] rdata;
		logic err;
		issue_access(addr, 1'b1, val, 4'hf, rdata, err);
		check(rdata, 32'd0, $sformatf("%s data", what));
		check(32'(err), 32'd1, $sformatf("%s error flag", what));
	endtask

	task automatic read_word(input logic [29:0] addr, input logic [31:0] exp_data,
			input logic exp_err, input string what);
		logic [31:0] rdata;
		logic err;
		issue_access(addr, 1'b0, 32'd0, 4'h0, rdata, err);
		check(rdata, exp_data, what);
		check(32'(err), 32'(exp_err), $sformatf("%s error flag", what));
	endtask

	task automatic fetch_word(input logic [29:0] addr, input logic [31:0] exp_data,
			input logic exp_err, input string what);
		int waited;
		logic got_ack;
		logic [31:0] rdata;
		logic err;
		@(negedge clk);
		f_access = 1'b1;
		f_addr = addr;
		waited = 0;
		got_ack = 1'b0;
		while (!got_ack) begin
			@(negedge clk);
			waited++;
			got_ack = f_ack;
			rdata = f_data;
			err = f_error;
			f_access = 1'b0;
			if (!got_ack && waited >= ACK_TIMEOUT)
				abort_run("timeout, no fetch ack arrived");
		end
		check(32'(waited), 32'd1, "fetch ack latency");
		check(rdata, exp_data, what);
		check(32'(err), 32'(exp_err), $sformatf("%s error flag", what));
	endtask

	task automatic ram_random_write(input logic [7:0] ofs, input logic [3:0] bsel);
		logic [31:0] val;
		val = $random(seed);
		ram_model[ofs] = merge_bytes(ram_model[ofs], val, bsel);
		write_word({RAM_PG, 2'b00, ofs}, val, bsel, 1'b0, "ram write");
	endtask

	task automatic byte_lane_writes();
		ram_random_write(8'd0, 4'hf);
		ram_random_write(8'd3, 4'hf);
		ram_random_write(8'd64, 4'hf);
		ram_random_write(8'd200, 4'hf);
		ram_random_write(8'd255, 4'hf);
		ram_random_write(8'd3, 4'b0101);
		ram_random_write(8'd64, 4'b1000);
		ram_random_write(8'd200, 4'b0010);
		ram_random_write(8'd255, 4'b0110);
		read_word({RAM_PG, 10'd0}, ram_model[8'd0], 1'b0, "ram word 0");
		read_word({RAM_PG, 10'd3}, ram_model[8'd3], 1'b0, "ram word 3");
		read_word({RAM_PG, 10'd64}, ram_model[8'd64], 1'b0, "ram word 64");
		read_word({RAM_PG, 10'd200}, ram_model[8'd200], 1'b0, "ram word 200");
		read_word({RAM_PG, 10'd255}, ram_model[8'd255], 1'b0, "ram word 255");
	endtask

	task automatic rom_and_ram_fetches();
		for (int i = 0; i < 16; i++)
			fetch_word({ROM_PG, 6'd0, 4'(i)}, rom_image[4'(i)], 1'b0, "rom fetch");
		fetch_word({RAM_PG, 10'd0}, ram_model[8'd0], 1'b0, "ram fetch word 0");
		fetch_word({RAM_PG, 10'd64}, ram_model[8'd64], 1'b0, "ram fetch word 64");
		fetch_word({RAM_PG, 10'd255}, ram_model[8'd255], 1'b0, "ram fetch word 255");
		fetch_word({IRQ_PG, 10'd0}, NOP_WORD, 1'b1, "fetch from irq page");
	endtask

	task automatic map_misses();
		read_word({HOLE_PG, 10'd0}, 32'd0, 1'b1, "unmapped page read");
		missed_write({20'hfffff, 10'd5}, 32'hdead_beef, "unmapped page write");
		read_word({RAM_PG, 10'd256}, 32'd0, 1'b1, "ram offset 256 read");
		missed_write({RAM_PG, 10'd259}, 32'h1234_5678, "ram offset 259 write");
		read_word({RAM_PG, 10'd3}, ram_model[8'd3], 1'b0, "ram word 3 after missed write");
		read_word({ROM_PG, 10'd16}, 32'd0, 1'b1, "rom offset 16 read");
		missed_write({ROM_PG, 10'd1023}, 32'h0, "rom offset 1023 write");
		write_word({ROM_PG, 10'd2}, ~rom_image[4'd2], 4'hf, 1'b0, "rom word 2 write");
		read_word({ROM_PG, 10'd2}, rom_image[4'd2], 1'b0, "rom word 2 after write");
		fetch_word({RAM_PG, 10'd300}, NOP_WORD, 1'b1, "fetch from ram offset 300");
	endtask

	task automatic irq_mask_and_clear();
		// the controller latches the rising edge on the next clock.
		@(negedge clk);
		ext_irqs = 2'b01;
		@(negedge clk);
		ext_irqs = 2'b00;
		read_word({IRQ_PG, 10'd0}, 32'h4, 1'b0, "irq status with line 2 pending");
		check(32'(irq_req), 32'd0, "irq request with mask zero");
		write_word({IRQ_PG, 10'd1}, 32'h4, 4'hf, 1'b0, "irq enable write");
		check(32'(irq_req), 32'd1, "irq request with line 2 enabled");
		read_word({IRQ_PG, 10'd1}, 32'h4, 1'b0, "irq enable read");
		write_word({IRQ_PG, 10'd0}, 32'h4, 4'hf, 1'b0, "irq status clear");
		check(32'(irq_req), 32'd0, "irq request after clear");
		read_word({IRQ_PG, 10'd0}, 32'h0, 1'b0, "irq status after clear");
		read_word({IRQ_PG, 10'd7}, 32'd0, 1'b1, "irq undefined offset read");
		write_word({IRQ_PG, 10'd5}, 32'h1, 4'hf, 1'b1, "irq undefined offset write");
	endtask

	task automatic timer_interrupt();
		int waited;
		write_word({IRQ_PG, 10'd1}, 32'h1, 4'hf, 1'b0, "irq enable for timer 0");
		write_word({TMR_PG, 10'd1}, 32'd20, 4'hf, 1'b0, "timer 0 reload write");
		read_word({TMR_PG, 10'd1}, 32'd20, 1'b0, "timer 0 reload read");
		read_word({TMR_PG, 10'd0}, 32'd20, 1'b0, "timer 0 count after reload");
		check(32'(irq_req), 32'd0, "irq request before timer start");
		write_word({TMR_PG, 10'd2}, 32'h1, 4'hf, 1'b0, "timer 0 enable");
		waited = 0;
		while (!irq_req) begin
			@(negedge clk);
			waited++;
			if (!irq_req && waited >= IRQ_TIMEOUT)
				abort_run("timeout, timer 0 never raised an interrupt");
		end
		read_word({IRQ_PG, 10'd0}, 32'h1, 1'b0, "irq status after timer 0");
		read_word({TMR_PG, 10'd2}, 32'h1, 1'b0, "timer 0 control read");
		write_word({TMR_PG, 10'd0}, 32'd5, 4'hf, 1'b1, "timer 0 count write");
		read_word({TMR_PG, 10'd3}, 32'd0, 1'b1, "timer 0 undefined offset");
		read_word({TMR_PG, 10'd8}, 32'd0, 1'b1, "timer 2 access");
		write_word({TMR_PG, 10'd2}, 32'h0, 4'hf, 1'b0, "timer 0 disable");
		write_word({IRQ_PG, 10'd0}, 32'h1, 4'hf, 1'b0, "irq status clear of timer 0");
		check(32'(irq_req), 32'd0, "irq request after timer clear");
	endtask

	initial begin
		errors = 0;
		seed = 92;
		arst_n = 1'b0;
		d_access = 1'b0;
		d_addr = '0;
		d_wr_val = '0;
		d_wr_en = 1'b0;
		d_bytesel = '0;
		f_access = 1'b0;
		f_addr = '0;
		ext_irqs = '0;
		$readmemh("design/boot_rom.hex", rom_image);
		if (^rom_image[0] === 1'bx)
			abort_run("the boot ROM hex file could not be read");
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		check(32'(d_ack), 32'd0, "data ack after reset");
		check(32'(d_error), 32'd0, "data error after reset");
		check(32'(f_ack), 32'd0, "fetch ack after reset");
		check(32'(f_error), 32'd0, "fetch error after reset");
		check(32'(irq_req), 32'd0, "irq request after reset");
		byte_lane_writes();
		rom_and_ram_fetches();
		map_misses();
		irq_mask_and_clear();
		timer_interrupt();
		if (errors == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run("errors were counted during the run");
		end
	end

endmodule

//--- design/boot_rom.hex
// one 32-bit hex word per line, starting at ROM word 0.
00000513
10000597
0005a603
00c52023
00450513
00458593
fe0598e3
800026b7
0006a703
00e6a223
80003737
01400793
00f72223
00100813
01072423
0000006f

//--- flist.f
design/soc_bus_pkg.sv
design/bus_if.sv
design/bus_addr_decode.sv
design/onchip_ram.sv
design/boot_rom.sv
design/irq_ctrl.sv
design/timer_block.sv
design/bus_response_mux.sv
design/soc_fabric_top.sv
tests/tb_soc_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_soc_fabric -f flist.f \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation finished without failure"
exit 0
